// File: rtr_settings.svh
/*
 * sizes and connectivity select for the route unit of one router input port
 * include wherever a size or the connectivity code is needed
 */
`ifndef RTR_SETTINGS_SVH
`define RTR_SETTINGS_SVH

// --------------------------------------------------
// network shape
// --------------------------------------------------

// routers along each dimension
`define RTR_ROUTERS_PER_DIM 4

// number of dimensions in the network
`define RTR_NUM_DIMS 2

// address bits for one dimension
`define RTR_DIM_ADDR_W 2

// full router address with dimension d at bits [d*dim_w +: dim_w]
`define RTR_ROUTER_ADDR_W (`RTR_NUM_DIMS * `RTR_DIM_ADDR_W)

// --------------------------------------------------
// classes and ports
// --------------------------------------------------

// class 0 is the intermediate phase and class 1 the final phase
`define RTR_NUM_RC 2

// two neighbours per dimension plus the single eject port
`define RTR_NUM_PORTS (2 * `RTR_NUM_DIMS + 1)

// flit payload bits
`define RTR_PAYLOAD_W 16

// connectivity codes in the same encoding as conn_e
`define RTR_CONN_LINE 1'b0
`define RTR_CONN_RING 1'b1

// ring by default
`define RTR_CONN `RTR_CONN_RING

`endif

// File: rtr_pkg.sv
/*
 * shared types for the route unit
 * flit types, connectivity, flits, route requests and routes
 */
`include "rtr_settings.svh"

package rtr_pkg;

   // --------------------------------------------------
   // enums
   // --------------------------------------------------

   // flit position within a packet
   typedef enum logic [1:0] {
      head      = 2'b00,
      body      = 2'b01,
      tail      = 2'b10,
      head_tail = 2'b11
   } flit_type_e;

   // connectivity inside one dimension
   typedef enum logic {
      conn_line = 1'b0,
      conn_ring = 1'b1
   } conn_e;

   // --------------------------------------------------
   // structs
   // --------------------------------------------------

   // phased dor destinations
   // intermediate router in the low half is used by class 0
   typedef struct packed {
      logic [`RTR_ROUTER_ADDR_W-1:0] final_addr;
      logic [`RTR_ROUTER_ADDR_W-1:0] inter_addr;
   } dest_info_s;

   // one flit as it travels through the port
   // head flits carry dest_info_s in the low payload bits
   typedef struct packed {
      flit_type_e                ftype;
      logic                      rc;
      logic [`RTR_PAYLOAD_W-1:0] payload;
   } flit_s;

   // input to the routing logic
   // sel_irc bit c set means the flit travels in class c
   typedef struct packed {
      dest_info_s             dest;
      logic [`RTR_NUM_RC-1:0] sel_irc;
   } route_req_s;

   // routing decision
   // port 2d goes down in dimension d and port 2d+1 goes up
   // top port is eject
   typedef struct packed {
      logic [`RTR_NUM_PORTS-1:0] route_op;
      logic [`RTR_NUM_RC-1:0]    route_orc;
   } route_s;

endpackage

// File: rtr_flit_decode.sv
/*
 * decode stage of the route unit
 * registers every flit strobe and pulls the route request out of head flits
 */
`timescale 1ns/1ns
`include "rtr_settings.svh"

module rtr_flit_decode (
   input  logic                clk,
   input  logic                reset,
   input  logic                flit_valid,
   input  rtr_pkg::flit_s      flit,
   output logic                dec_valid,
   output rtr_pkg::flit_s      dec_flit,
   output rtr_pkg::route_req_s dec_req
);

   import rtr_pkg::*;

   logic                   is_head;
   logic [`RTR_NUM_RC-1:0] irc_onehot;
   dest_info_s             dest_in;

   // --------------------------------------------------
   // head field extraction
   // --------------------------------------------------

   // head and head_tail both start a route
   assign is_head = (flit.ftype == head) || (flit.ftype == head_tail);

   // destinations sit in the low payload bits
   assign dest_in = dest_info_s'(flit.payload[$bits(dest_info_s)-1:0]);

   // incoming class bit to one-hot select
   always_comb
   begin
      irc_onehot = '0;
      irc_onehot[flit.rc] = 1'b1;
   end

   // --------------------------------------------------
   // registers
   // --------------------------------------------------

   // strobe is control state
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         dec_valid <= 1'b0;
      end
      else
      begin
         dec_valid <= flit_valid;
      end
   end

   // flit and request only load on a strobe
   always_ff @(posedge clk)
   begin
      if (flit_valid)
      begin
         dec_flit <= flit;
         // body and tail keep the old request
         // so the routing logic stays quiet
         if (is_head)
         begin
            dec_req.dest    <= dest_in;
            dec_req.sel_irc <= irc_onehot;
         end
      end
   end

endmodule

// File: rtr_routing_logic_desc.sv
/*
 * phased dimension-order routing with dimensions resolved in descending order
 * purely combinational and fed by the registered request of the decode stage
 * line or ring connectivity is picked by RTR_CONN
 */
`timescale 1ns/1ns
`include "rtr_settings.svh"

module rtr_routing_logic_desc (
   input  logic [`RTR_ROUTER_ADDR_W-1:0] router_address,
   input  rtr_pkg::route_req_s           req,
   output rtr_pkg::route_s               route
);

   import rtr_pkg::*;

   localparam int    dim_w    = `RTR_DIM_ADDR_W;
   localparam int    addr_w   = `RTR_ROUTER_ADDR_W;
   localparam int    num_dims = `RTR_NUM_DIMS;
   localparam int    num_rc   = `RTR_NUM_RC;
   localparam int    num_net  = 2 * `RTR_NUM_DIMS;
   localparam conn_e conn_sel = conn_e'(`RTR_CONN);

   // all destinations with class c at [c*addr_w +: addr_w]
   logic [num_rc*addr_w-1:0] dest_bits;

   // network port choice per class
   logic [num_net-1:0]       onp_rc [num_rc];
   logic [num_rc-1:0]        reached_rc;
   logic [num_rc-2:0]        done_rc;
   logic [num_rc-1:0]        orc;
   logic [num_net-1:0]       onp_sel;
   logic                     eject;

   assign dest_bits = req.dest;

   // --------------------------------------------------
   // per class port decision
   // --------------------------------------------------

   for (genvar rc = 0; rc < num_rc; rc++)
   begin : g_rc
      logic [addr_w-1:0]   dest_addr;
      logic [num_dims-1:0] match_d;

      assign dest_addr = dest_bits[rc*addr_w +: addr_w];

      for (genvar d = 0; d < num_dims; d++)
      begin : g_dim
         logic [dim_w-1:0] dest_d;
         logic [dim_w-1:0] curr_d;
         logic             dim_sel;
         logic             go_down;
         logic             go_up;

         assign dest_d     = dest_addr[d*dim_w +: dim_w];
         assign curr_d     = router_address[d*dim_w +: dim_w];
         assign match_d[d] = (dest_d == curr_d);

         // top dimension always active
         // lower ones only once everything above matches
         if (d == num_dims - 1)
         begin : g_top
            assign dim_sel = 1'b1;
         end
         else
         begin : g_lower
            assign dim_sel = &match_d[num_dims-1:d+1];
         end

         if (conn_sel == conn_line)
         begin : g_line
            // no wrap so step straight toward the target
            assign go_down = (dest_d < curr_d);
            assign go_up   = (dest_d > curr_d);
         end
         else
         begin : g_ring
            localparam logic [dim_w:0] ring_size = `RTR_ROUTERS_PER_DIM;

            logic [dim_w-1:0] up_dist;
            logic [dim_w:0]   up_dist_x2;
            logic             tie;

            // hops going up with wrap
            assign up_dist    = dest_d - curr_d;
            assign up_dist_x2 = {up_dist, 1'b0};
            // exactly half way round
            assign tie        = (up_dist_x2 == ring_size);

            // even routers break the tie upward and odd ones downward
            assign go_up   = ~match_d[d] & ((up_dist_x2 < ring_size) | (tie & ~curr_d[0]));
            assign go_down = ~match_d[d] & ((up_dist_x2 > ring_size) | (tie & curr_d[0]));
         end

         assign onp_rc[rc][2*d +: 2] = {go_up, go_down} & {2{dim_sel}};
      end

      // all dimensions match
      assign reached_rc[rc] = &match_d;
   end

   // --------------------------------------------------
   // class update and port select
   // --------------------------------------------------

   // a non-final class has arrived at its router
   assign done_rc = req.sel_irc[num_rc-2:0] & reached_rc[num_rc-2:0];

   // finishing a non-final class moves the flit to the next class
   assign orc = (|done_rc) ? {req.sel_irc[num_rc-2:0], 1'b0} : req.sel_irc;

   // outgoing class is final and its router is reached
   assign eject = orc[num_rc-1] & reached_rc[num_rc-1];

   // port follows the outgoing class
   always_comb
   begin
      onp_sel = '0;
      for (int c = 0; c < num_rc; c++)
      begin
         onp_sel = onp_sel | (onp_rc[c] & {num_net{orc[c]}});
      end
   end

   assign route.route_op  = {eject, onp_sel};
   assign route.route_orc = orc;

endmodule

// File: rtr_route_result.sv
/*
 * result stage of the route unit
 * registers the route with head flits and replays it for body and tail flits
 * flags body or tail flits that turn up with no packet open
 */
`timescale 1ns/1ns

module rtr_route_result (
   input  logic            clk,
   input  logic            reset,
   input  logic            dec_valid,
   input  rtr_pkg::flit_s  dec_flit,
   input  rtr_pkg::route_s route,
   output logic            out_valid,
   output rtr_pkg::flit_s  out_flit,
   output rtr_pkg::route_s out_route,
   output logic            orphan_error
);

   import rtr_pkg::*;

   logic   pkt_open;
   route_s held_route;
   logic   is_head;
   logic   is_end;
   logic   orphan;
   route_s route_sel;

   // --------------------------------------------------
   // flit classification
   // --------------------------------------------------

   // head_tail opens and closes in one flit
   assign is_head = (dec_flit.ftype == head) || (dec_flit.ftype == head_tail);
   assign is_end  = (dec_flit.ftype == tail) || (dec_flit.ftype == head_tail);

   // body or tail with nothing to follow
   assign orphan = dec_valid & ~is_head & ~pkt_open;

   // fresh route for heads and held route for the rest
   always_comb
   begin
      if (is_head)
      begin
         route_sel = route;
      end
      else if (pkt_open)
      begin
         route_sel = held_route;
      end
      else
      begin
         // orphans leave with no port and no class
         route_sel = '0;
      end
   end

   // --------------------------------------------------
   // packet state
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_valid    <= 1'b0;
         pkt_open     <= 1'b0;
         held_route   <= '0;
         orphan_error <= 1'b0;
      end
      else
      begin
         out_valid <= dec_valid;
         if (dec_valid)
         begin
            if (is_head)
            begin
               held_route <= route;
            end
            if (is_end)
            begin
               pkt_open <= 1'b0;
            end
            else if (is_head)
            begin
               pkt_open <= 1'b1;
            end
         end
         // sticky until reset
         if (orphan)
         begin
            orphan_error <= 1'b1;
         end
      end
   end

   // output flit and route
   always_ff @(posedge clk)
   begin
      if (dec_valid)
      begin
         out_flit  <= dec_flit;
         out_route <= route_sel;
      end
   end

endmodule

// File: rtr_route_unit.sv
/*
 * routing stage of one router input port
 * decode then combinational routing then result with two cycles of latency
 */
`timescale 1ns/1ns
`include "rtr_settings.svh"

module rtr_route_unit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [`RTR_ROUTER_ADDR_W-1:0] router_address,
   input  logic                          flit_valid,
   input  rtr_pkg::flit_s                flit,
   output logic                          out_valid,
   output rtr_pkg::flit_s                out_flit,
   output rtr_pkg::route_s               out_route,
   output logic                          orphan_error
);

   import rtr_pkg::*;

   // decode to routing and result
   logic       dec_valid;
   flit_s      dec_flit;
   route_req_s dec_req;

   // combinational decision
   route_s     route;

   // first cycle registers the flit
   rtr_flit_decode decode_i (
      .clk        (clk),
      .reset      (reset),
      .flit_valid (flit_valid),
      .flit       (flit),
      .dec_valid  (dec_valid),
      .dec_flit   (dec_flit),
      .dec_req    (dec_req)
   );

   // same cycle as the decode register output
   rtr_routing_logic_desc routing_i (
      .router_address (router_address),
      .req            (dec_req),
      .route          (route)
   );

   // second cycle registers the result
   rtr_route_result result_i (
      .clk          (clk),
      .reset        (reset),
      .dec_valid    (dec_valid),
      .dec_flit     (dec_flit),
      .route        (route),
      .out_valid    (out_valid),
      .out_flit     (out_flit),
      .out_route    (out_route),
      .orphan_error (orphan_error)
   );

endmodule

// File: rtr_route_unit_tb.sv
/*
 * testbench for the route unit of one router input port
 * random packets against a reference routing model, then an orphan flit phase
 */
`timescale 1ns/1ns
`include "rtr_settings.svh"

module rtr_route_unit_tb;

   import rtr_pkg::*;

   localparam int addr_w    = `RTR_ROUTER_ADDR_W;
   localparam int dim_w     = `RTR_DIM_ADDR_W;
   localparam int payload_w = `RTR_PAYLOAD_W;
   localparam int num_pkts  = 300;

   // one predicted output with the cycle it is due in
   typedef struct packed {
      logic [31:0] due;
      flit_s       flit;
      route_s      route;
      logic        orphan;
   } exp_s;

   logic              clk;
   logic              reset;
   logic [addr_w-1:0] router_address;
   logic              flit_valid;
   flit_s             flit;
   logic              out_valid;
   flit_s             out_flit;
   route_s            out_route;
   logic              orphan_error;

   // model state
   exp_s   exp_q [$];
   int     cyc = 0;
   logic   pkt_open;
   logic   prev_head;
   logic   orphan_model;
   route_s held;

   rtr_route_unit dut_i (
      .clk            (clk),
      .reset          (reset),
      .router_address (router_address),
      .flit_valid     (flit_valid),
      .flit           (flit),
      .out_valid      (out_valid),
      .out_flit       (out_flit),
      .out_route      (out_route),
      .orphan_error   (orphan_error)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // posedge count read only on falling edges
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // --------------------------------------------------
   // reference routing
   // --------------------------------------------------

   // neighbour ports toward tgt in the highest dimension that differs
   function automatic logic [2*`RTR_NUM_DIMS-1:0] dim_ports(input logic [addr_w-1:0] addr,
                                                            input logic [addr_w-1:0] tgt);
      logic [2*`RTR_NUM_DIMS-1:0] ports;
      int cur;
      int dst;
      int up_hops;
      logic up;
      ports = '0;
      for (int d = `RTR_NUM_DIMS - 1; d >= 0; d--)
      begin
         cur = addr[d*dim_w +: dim_w];
         dst = tgt[d*dim_w +: dim_w];
         if (ports == '0 && cur != dst)
         begin
            if (`RTR_CONN == `RTR_CONN_LINE)
            begin
               up = (dst > cur);
            end
            else
            begin
               up_hops = (dst - cur + `RTR_ROUTERS_PER_DIM) % `RTR_ROUTERS_PER_DIM;
               if (2 * up_hops == `RTR_ROUTERS_PER_DIM)
                  up = (cur % 2 == 0);
               else
                  up = (2 * up_hops < `RTR_ROUTERS_PER_DIM);
            end
            ports[2*d + (up ? 1 : 0)] = 1'b1;
         end
      end
      return ports;
   endfunction

   function automatic route_s predict_route(input logic [addr_w-1:0] addr,
                                            input dest_info_s dest, input logic rc);
      route_s r;
      if (rc == 1'b0 && dest.inter_addr != addr)
      begin
         r.route_orc = 2'b01;
         r.route_op  = {1'b0, dim_ports(addr, dest.inter_addr)};
      end
      else
      begin
         // final class heads for the final router and ejects there
         r.route_orc = 2'b10;
         r.route_op  = {dest.final_addr == addr, dim_ports(addr, dest.final_addr)};
      end
      return r;
   endfunction

   // --------------------------------------------------
   // cycle step with output check
   // --------------------------------------------------

   task automatic step_cycle();
      exp_s e;
      logic exp_valid;
      @(negedge clk);
      exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cyc);
      compare("out_valid", out_valid, exp_valid);
      if (exp_valid)
      begin
         e = exp_q.pop_front();
         if (e.orphan)
            orphan_model = 1'b1;
         compare("out_flit", out_flit, e.flit);
         compare("out_route", out_route, e.route);
      end
      compare("orphan_error", orphan_error, orphan_model);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         step_cycle();
         flit_valid = 1'b0;
         prev_head  = 1'b0;
      end
   endtask

   // the head's route is taken one cycle after its strobe
   // so the address holds for the cycle right behind a head
   task automatic send_flit(input flit_type_e ft, input logic move);
      flit_s f;
      exp_s  e;
      logic  hd;
      step_cycle();
      hd = (ft == head) || (ft == head_tail);
      if (move && !prev_head)
         router_address = addr_w'($urandom);
      f.ftype   = ft;
      f.rc      = 1'($urandom);
      f.payload = payload_w'($urandom);
      e.due     = cyc + 2;
      e.flit    = f;
      e.orphan  = 1'b0;
      if (hd)
      begin
         e.route = predict_route(router_address, dest_info_s'(f.payload[7:0]), f.rc);
         held    = e.route;
      end
      else if (pkt_open)
         e.route = held;
      else
      begin
         e.route  = '0;
         e.orphan = 1'b1;
      end
      if (ft == head)
         pkt_open = 1'b1;
      else if (ft == tail || ft == head_tail)
         pkt_open = 1'b0;
      exp_q.push_back(e);
      flit_valid = 1'b1;
      flit       = f;
      prev_head  = hd;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() > 0)
      begin
         idle_cycles(1);
         n++;
         if (n > 20)
         begin
            $display("timeout: expected outputs never appeared");
            $display("Simulation FAILED");
            $fatal(1);
         end
      end
   endtask

   task automatic apply_reset();
      step_cycle();
      reset        = 1'b1;
      flit_valid   = 1'b0;
      pkt_open     = 1'b0;
      prev_head    = 1'b0;
      orphan_model = 1'b0;
      repeat (10) step_cycle();
      reset = 1'b0;
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------

   initial
   begin
      int len;
      void'($urandom(32'h7b3f));
      reset          = 1'b1;
      flit_valid     = 1'b0;
      flit           = '0;
      router_address = '0;
      pkt_open       = 1'b0;
      prev_head      = 1'b0;
      orphan_model   = 1'b0;
      held           = '0;
      repeat (10) step_cycle();
      reset = 1'b0;
      idle_cycles(5);

      // well formed packets with gaps and address moves
      for (int p = 0; p < num_pkts; p++)
      begin
         len = 1 + ($urandom % 4);
         for (int i = 0; i < len; i++)
         begin
            if ($urandom % 4 == 0)
               idle_cycles(1 + ($urandom % 2));
            if (len == 1)
               send_flit(head_tail, $urandom % 2 == 0);
            else if (i == 0)
               send_flit(head, $urandom % 2 == 0);
            else
               send_flit((i == len - 1) ? tail : body, $urandom % 4 == 0);
         end
      end
      drain();

      // orphan phase on a fresh reset
      apply_reset();
      idle_cycles(3);
      send_flit(body, 1'b0);
      idle_cycles(2);
      send_flit(tail, 1'b0);
      send_flit(head_tail, 1'b1);
      send_flit(head, 1'b0);
      send_flit(tail, 1'b0);
      drain();
      idle_cycles(5);

      // sticky flag drops only on reset
      apply_reset();
      idle_cycles(2);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: list.f
+incdir+.
rtr_pkg.sv
rtr_flit_decode.sv
rtr_routing_logic_desc.sv
rtr_route_result.sv
rtr_route_unit.sv
rtr_route_unit_tb.sv

// File: Bender.yml
package:
  name: rtr_route_unit

sources:
  - include_dirs:
      - .
    files:
      - rtr_pkg.sv
      - rtr_flit_decode.sv
      - rtr_routing_logic_desc.sv
      - rtr_route_result.sv
      - rtr_route_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - rtr_route_unit_tb.sv
